// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module irda_tb -f compile.f -o irda_sim
	./obj_dir/irda_sim | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: compile.f
rtl/irda_pkg.sv
rtl/irda_fifo.sv
rtl/irda_regs.sv
rtl/irda_tx_framer.sv
rtl/irda_interrupts.sv
rtl/irda_ctrl_top.sv
verif/irda_asserts.sv
verif/irda_tb.sv

// File: rtl/irda_ctrl_top.sv
`timescale 1ns/1ps

module irda_ctrl_top (
	input  logic            clk,
	input  logic            wb_rst_i,
	// host register access
	input  logic            reg_wr_i,
	input  logic            reg_rd_i,
	input  logic [2:0]      reg_addr_i,
	input  irda_pkg::byte_t reg_wdata_i,
	output irda_pkg::byte_t reg_rdata_o,
	// receive side from the demodulator
	input  logic            rx_valid_i,
	input  irda_pkg::byte_t rx_data_i,
	input  logic            rx_eof_i,
	input  logic            rx_crc_err_i,
	input  logic            rx_err_i,
	// transmit side to the modulator
	input  logic            tx_slot_i,
	output logic            tx_valid_o,
	output irda_pkg::byte_t tx_data_o,
	input  logic            user_int_i,
	output logic            int_o,
	output logic            dma_req_t_o,
	input  logic            dma_ack_t_i,
	output logic            dma_req_r_o,
	input  logic            dma_ack_r_i
);
	import irda_pkg::*;

	byte_t         rx_head;
	byte_t         tx_head;
	byte_t         tx_len;
	fifo_count_t   rx_count;
	fifo_count_t   tx_count;
	iir_t          iir;
	ier_t          ier;
	trig_level_t   rx_trig_level;
	trig_level_t   tx_trig_level;
	framer_state_t framer_state;
	logic          rx_pop;
	logic          rx_overrun;
	logic          tx_push;
	logic          tx_pop;
	logic          tx_start;
	logic          tx_underrun;
	logic          iir_read;
	logic          use_dma;

	irda_regs u_regs (
		.clk             (clk),
		.wb_rst_i        (wb_rst_i),
		.reg_wr_i        (reg_wr_i),
		.reg_rd_i        (reg_rd_i),
		.reg_addr_i      (reg_addr_i),
		.reg_wdata_i     (reg_wdata_i),
		.reg_rdata_o     (reg_rdata_o),
		.rx_head_i       (rx_head),
		.iir_i           (iir),
		.rx_pop_o        (rx_pop),
		.tx_push_o       (tx_push),
		.iir_read_o      (iir_read),
		.tx_start_o      (tx_start),
		.use_dma_o       (use_dma),
		.ier_o           (ier),
		.rx_trig_level_o (rx_trig_level),
		.tx_trig_level_o (tx_trig_level),
		.tx_len_o        (tx_len)
	);

	irda_fifo rx_fifo (
		.clk       (clk),
		.wb_rst_i  (wb_rst_i),
		.push_i    (rx_valid_i),
		.pop_i     (rx_pop),
		.wdata_i   (rx_data_i),
		.rdata_o   (rx_head),
		.count_o   (rx_count),
		.overrun_o (rx_overrun)
	);

	// host writes past a full tx fifo are simply lost
	irda_fifo tx_fifo (
		.clk       (clk),
		.wb_rst_i  (wb_rst_i),
		.push_i    (tx_push),
		.pop_i     (tx_pop),
		.wdata_i   (reg_wdata_i),
		.rdata_o   (tx_head),
		.count_o   (tx_count),
		.overrun_o ()
	);

	irda_tx_framer u_framer (
		.clk          (clk),
		.wb_rst_i     (wb_rst_i),
		.tx_start_i   (tx_start),
		.tx_slot_i    (tx_slot_i),
		.tx_len_i     (tx_len),
		.fifo_head_i  (tx_head),
		.fifo_count_i (tx_count),
		.fifo_pop_o   (tx_pop),
		.tx_valid_o   (tx_valid_o),
		.tx_data_o    (tx_data_o),
		.state_o      (framer_state),
		.underrun_o   (tx_underrun)
	);

	irda_interrupts u_interrupts (
		.clk             (clk),
		.wb_rst_i        (wb_rst_i),
		.ier_i           (ier),
		.rx_trig_level_i (rx_trig_level),
		.tx_trig_level_i (tx_trig_level),
		.rx_count_i      (rx_count),
		.tx_count_i      (tx_count),
		.user_int_i      (user_int_i),
		.sto_detected_i  (rx_eof_i),
		.crc_error_i     (rx_crc_err_i),
		.rx_overrun_i    (rx_overrun),
		.rx_error_i      (rx_err_i),
		.tx_underrun_i   (tx_underrun),
		.framer_state_i  (framer_state),
		.iir_read_i      (iir_read),
		.use_dma_i       (use_dma),
		.dma_ack_t_i     (dma_ack_t_i),
		.dma_ack_r_i     (dma_ack_r_i),
		.int_o           (int_o),
		.iir_o           (iir),
		.dma_req_t_o     (dma_req_t_o),
		.dma_req_r_o     (dma_req_r_o)
	);

endmodule

// File: rtl/irda_fifo.sv
`timescale 1ns/1ps

module irda_fifo #(
	parameter int DEPTH = irda_pkg::FIFO_DEPTH
) (
	input  logic                  clk,
	input  logic                  wb_rst_i,
	input  logic                  push_i,
	input  logic                  pop_i,
	input  irda_pkg::byte_t       wdata_i,
	output irda_pkg::byte_t       rdata_o,
	output irda_pkg::fifo_count_t count_o,
	output logic                  overrun_o
);
	import irda_pkg::*;

	byte_t mem [DEPTH];

	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic                  full;
	logic                  pop_ok;
	logic                  push_ok;

	assign full    = (count_o == fifo_count_t'(DEPTH));
	// a pop on an empty fifo does nothing
	assign pop_ok  = pop_i && (count_o != '0);
	// a full fifo still accepts a byte when a pop frees a slot in the same cycle
	assign push_ok = push_i && (!full || pop_ok);

	assign overrun_o = push_i && !push_ok;
	assign rdata_o   = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push_ok) begin
			mem[wr_ptr] <= wdata_i;
		end
	end

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_o <= '0;
		end else begin
			// pointers wrap on their own since the depth is a power of two
			if (push_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push_ok, pop_ok})
				2'b10:   count_o <= count_o + 1'b1;
				2'b01:   count_o <= count_o - 1'b1;
				default: count_o <= count_o;
			endcase
		end
	end

endmodule

// File: rtl/irda_interrupts.sv
`timescale 1ns/1ps

module irda_interrupts (
	input  logic                    clk,
	input  logic                    wb_rst_i,
	input  irda_pkg::ier_t          ier_i,
	input  irda_pkg::trig_level_t   rx_trig_level_i,
	input  irda_pkg::trig_level_t   tx_trig_level_i,
	input  irda_pkg::fifo_count_t   rx_count_i,
	input  irda_pkg::fifo_count_t   tx_count_i,
	input  logic                    user_int_i,
	input  logic                    sto_detected_i,
	input  logic                    crc_error_i,
	input  logic                    rx_overrun_i,
	input  logic                    rx_error_i,
	input  logic                    tx_underrun_i,
	input  irda_pkg::framer_state_t framer_state_i,
	input  logic                    iir_read_i,
	input  logic                    use_dma_i,
	input  logic                    dma_ack_t_i,
	input  logic                    dma_ack_r_i,
	output logic                    int_o,
	output irda_pkg::iir_t          iir_o,
	output logic                    dma_req_t_o,
	output logic                    dma_req_r_o
);
	import irda_pkg::*;

	fifo_count_t rx_thresh;
	fifo_count_t tx_thresh;
	logic        rx_trig_active;
	logic        tx_trig_active;
	logic        tx_busy;
	ier_t        src;
	ier_t        src_prev_n;
	ier_t        rise;
	iir_t        iir_kept;

	////////////////////////////////////////////////////////////////////////////
	// fifo trigger comparators
	////////////////////////////////////////////////////////////////////////////

	// each trigger level moves the threshold by one step of two bytes
	assign rx_thresh = fifo_count_t'(RX_TRIG_BASE + TRIG_STEP * int'(rx_trig_level_i));
	assign tx_thresh = fifo_count_t'(TX_TRIG_BASE + TRIG_STEP * int'(tx_trig_level_i));

	assign rx_trig_active = (rx_count_i >= rx_thresh);
	assign tx_trig_active = (tx_count_i <= tx_thresh);

	// the transmitter counts as busy for the whole frame, stop slot included
	assign tx_busy = (framer_state_i != FR_IDLE);

	////////////////////////////////////////////////////////////////////////////
	// rise detection
	////////////////////////////////////////////////////////////////////////////

	// source order follows iir bits 0 to 6 so the ier mask lines up directly
	assign src = {tx_underrun_i, tx_trig_active, rx_error_i, rx_overrun_i,
		crc_error_i, sto_detected_i, rx_trig_active};

	// the flops hold the inverted last value, reset to zero so that a source
	// already active when reset drops does not count as a rise
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			src_prev_n <= '0;
		end else begin
			src_prev_n <= ~src;
		end
	end

	assign rise = src & src_prev_n;

	////////////////////////////////////////////////////////////////////////////
	// status register
	////////////////////////////////////////////////////////////////////////////

	// a host read drops the sticky bits, new events in that cycle still land
	assign iir_kept = iir_read_i ? (iir_o & IIR_KEEP_MASK) : iir_o;

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			iir_o <= '0;
		end else begin
			iir_o[7] <= tx_busy;
			iir_o[6] <= iir_kept[6] | tx_underrun_i;
			iir_o[5] <= tx_trig_active;
			iir_o[4] <= iir_kept[4] | rx_error_i;
			iir_o[3] <= iir_kept[3] | rx_overrun_i;
			iir_o[2] <= iir_kept[2] | crc_error_i;
			iir_o[1] <= iir_kept[1] | sto_detected_i;
			iir_o[0] <= rx_trig_active;
		end
	end

	// one pulse per enabled rise, user interrupt passes straight through
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			int_o <= 1'b0;
		end else begin
			int_o <= user_int_i | (|(ier_i & rise));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// dma requests
	////////////////////////////////////////////////////////////////////////////

	// receive side asks for the fifo to be drained once the trigger is reached
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			dma_req_r_o <= 1'b0;
		end else if (!use_dma_i) begin
			dma_req_r_o <= 1'b0;
		end else if (rise[0]) begin
			dma_req_r_o <= 1'b1;
		end else if (dma_ack_r_i) begin
			dma_req_r_o <= 1'b0;
		end
	end

	// transmit side asks for a refill when the fifo falls to its low level
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			dma_req_t_o <= 1'b0;
		end else if (!use_dma_i) begin
			dma_req_t_o <= 1'b0;
		end else if (rise[5]) begin
			dma_req_t_o <= 1'b1;
		end else if (dma_ack_t_i) begin
			dma_req_t_o <= 1'b0;
		end
	end

endmodule

// File: rtl/irda_pkg.sv
package irda_pkg;

	// fifo geometry shared by the receive and transmit directions
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_PTR_W = 4;

	typedef logic [7:0]            byte_t;
	typedef logic [FIFO_PTR_W:0]   fifo_count_t;
	typedef logic [6:0]            ier_t;
	typedef logic [7:0]            iir_t;
	typedef logic [1:0]            trig_level_t;

	// rx trigger fires at or above 8 + 2*level, tx trigger at or below 2 + 2*level
	localparam int RX_TRIG_BASE = 8;
	localparam int TX_TRIG_BASE = 2;
	localparam int TRIG_STEP    = 2;

	// level bits that are not cleared when the host reads the iir
	localparam iir_t IIR_KEEP_MASK = 8'b1010_0001;

	localparam byte_t PREAMBLE_BYTE = 8'hC0;

	////////////////////////////////////////////////////////////////////////////
	// host register map
	////////////////////////////////////////////////////////////////////////////

	localparam logic [2:0] ADDR_RXDATA = 3'd0;
	localparam logic [2:0] ADDR_TXDATA = 3'd1;
	localparam logic [2:0] ADDR_IER    = 3'd2;
	localparam logic [2:0] ADDR_IIR    = 3'd3;
	// fcr holds rx level in 1:0, tx level in 3:2 and use_dma in bit 4
	localparam logic [2:0] ADDR_FCR    = 3'd4;
	localparam logic [2:0] ADDR_TXLEN  = 3'd5;
	localparam logic [2:0] ADDR_CTRL   = 3'd6;

	// frame builder states
	typedef enum logic [1:0] {
		FR_IDLE     = 2'd0,
		FR_PREAMBLE = 2'd1,
		FR_DATA     = 2'd2,
		FR_STOP     = 2'd3
	} framer_state_t;

endpackage

// File: rtl/irda_regs.sv
`timescale 1ns/1ps

module irda_regs (
	input  logic                  clk,
	input  logic                  wb_rst_i,
	input  logic                  reg_wr_i,
	input  logic                  reg_rd_i,
	input  logic [2:0]            reg_addr_i,
	input  irda_pkg::byte_t       reg_wdata_i,
	output irda_pkg::byte_t       reg_rdata_o,
	input  irda_pkg::byte_t       rx_head_i,
	input  irda_pkg::iir_t        iir_i,
	output logic                  rx_pop_o,
	output logic                  tx_push_o,
	output logic                  iir_read_o,
	output logic                  tx_start_o,
	output logic                  use_dma_o,
	output irda_pkg::ier_t        ier_o,
	output irda_pkg::trig_level_t rx_trig_level_o,
	output irda_pkg::trig_level_t tx_trig_level_o,
	output irda_pkg::byte_t       tx_len_o
);
	import irda_pkg::*;

	logic wr_ier;
	logic wr_fcr;
	logic wr_txlen;

	////////////////////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////////////////////

	// strobes are combinational so they act at the same edge as the host access
	assign rx_pop_o   = reg_rd_i && (reg_addr_i == ADDR_RXDATA);
	assign iir_read_o = reg_rd_i && (reg_addr_i == ADDR_IIR);
	assign tx_push_o  = reg_wr_i && (reg_addr_i == ADDR_TXDATA);
	assign tx_start_o = reg_wr_i && (reg_addr_i == ADDR_CTRL) && reg_wdata_i[0];

	assign wr_ier   = reg_wr_i && (reg_addr_i == ADDR_IER);
	assign wr_fcr   = reg_wr_i && (reg_addr_i == ADDR_FCR);
	assign wr_txlen = reg_wr_i && (reg_addr_i == ADDR_TXLEN);

	////////////////////////////////////////////////////////////////////////////
	// configuration registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			ier_o           <= '0;
			rx_trig_level_o <= '0;
			tx_trig_level_o <= '0;
			use_dma_o       <= 1'b0;
			tx_len_o        <= '0;
		end else begin
			if (wr_ier) begin
				ier_o <= reg_wdata_i[6:0];
			end
			if (wr_fcr) begin
				rx_trig_level_o <= reg_wdata_i[1:0];
				tx_trig_level_o <= reg_wdata_i[3:2];
				use_dma_o       <= reg_wdata_i[4];
			end
			if (wr_txlen) begin
				tx_len_o <= reg_wdata_i;
			end
		end
	end

	// read data is held until the next read strobe
	// the iir value captured here is the one from before the read clears it
	always_ff @(posedge clk) begin
		if (reg_rd_i) begin
			case (reg_addr_i)
				ADDR_RXDATA: reg_rdata_o <= rx_head_i;
				ADDR_IIR:    reg_rdata_o <= iir_i;
				ADDR_IER:    reg_rdata_o <= {1'b0, ier_o};
				default:     reg_rdata_o <= '0;
			endcase
		end
	end

endmodule

// File: rtl/irda_tx_framer.sv
`timescale 1ns/1ps

module irda_tx_framer (
	input  logic                    clk,
	input  logic                    wb_rst_i,
	input  logic                    tx_start_i,
	input  logic                    tx_slot_i,
	input  irda_pkg::byte_t         tx_len_i,
	input  irda_pkg::byte_t         fifo_head_i,
	input  irda_pkg::fifo_count_t   fifo_count_i,
	output logic                    fifo_pop_o,
	output logic                    tx_valid_o,
	output irda_pkg::byte_t         tx_data_o,
	output irda_pkg::framer_state_t state_o,
	output logic                    underrun_o
);
	import irda_pkg::*;

	framer_state_t state;
	byte_t         remaining;
	logic          data_slot;
	logic          fifo_empty;

	assign data_slot  = tx_slot_i && (state == FR_DATA);
	assign fifo_empty = (fifo_count_i == '0);

	// a data slot either takes the head byte or reports the missing byte
	assign fifo_pop_o = data_slot && !fifo_empty;
	assign underrun_o = data_slot && fifo_empty;
	assign state_o    = state;

	////////////////////////////////////////////////////////////////////////////
	// frame sequencing
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			state      <= FR_IDLE;
			remaining  <= '0;
			tx_valid_o <= 1'b0;
		end else begin
			tx_valid_o <= 1'b0;
			case (state)
				FR_IDLE: begin
					if (tx_start_i) begin
						remaining <= tx_len_i;
						state     <= FR_PREAMBLE;
					end
				end
				FR_PREAMBLE: begin
					if (tx_slot_i) begin
						tx_valid_o <= 1'b1;
						// an empty frame has nothing after the preamble
						state <= (remaining == '0) ? FR_STOP : FR_DATA;
					end
				end
				FR_DATA: begin
					if (underrun_o) begin
						state <= FR_STOP;
					end else if (fifo_pop_o) begin
						tx_valid_o <= 1'b1;
						remaining  <= remaining - 1'b1;
						if (remaining == 8'd1) begin
							state <= FR_STOP;
						end
					end
				end
				FR_STOP: begin
					// the stop slot carries no byte
					if (tx_slot_i) begin
						state <= FR_IDLE;
					end
				end
				default: state <= FR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (tx_slot_i && (state == FR_PREAMBLE)) begin
			tx_data_o <= PREAMBLE_BYTE;
		end else if (fifo_pop_o) begin
			tx_data_o <= fifo_head_i;
		end
	end

endmodule

// File: verif/irda_asserts.sv
`timescale 1ns/1ps

module irda_asserts (
	input logic clk,
	input logic wb_rst_i,
	input logic use_dma_i,
	input logic dma_ack_r_i,
	input logic int_o,
	input logic dma_req_r_o,
	input logic dma_req_t_o
);

	// interrupt and both requests stay at their reset value while reset is held
	property p_quiet_in_reset;
		@(posedge clk) wb_rst_i |-> (!int_o && !dma_req_r_o && !dma_req_t_o);
	endproperty

	// a pending receive request waits for its acknowledge or for dma to be switched off
	property p_rx_req_held;
		@(posedge clk) disable iff (wb_rst_i)
			(dma_req_r_o && !dma_ack_r_i && use_dma_i) |=> dma_req_r_o;
	endproperty

	property p_tx_req_needs_dma;
		@(posedge clk) disable iff (wb_rst_i)
			$rose(dma_req_t_o) |-> $past(use_dma_i);
	endproperty

	a_quiet_in_reset: assert property (p_quiet_in_reset)
		else $error("interrupt or dma request active during reset");
	a_rx_req_held: assert property (p_rx_req_held)
		else $error("receive dma request dropped without acknowledge");
	a_tx_req_needs_dma: assert property (p_tx_req_needs_dma)
		else $error("transmit dma request raised with dma disabled");

endmodule

bind irda_interrupts irda_asserts u_asserts (
	.clk         (clk),
	.wb_rst_i    (wb_rst_i),
	.use_dma_i   (use_dma_i),
	.dma_ack_r_i (dma_ack_r_i),
	.int_o       (int_o),
	.dma_req_r_o (dma_req_r_o),
	.dma_req_t_o (dma_req_t_o)
);

// File: verif/irda_tb.sv
`timescale 1ns/1ps

module irda_tb;
	import irda_pkg::*;

	localparam int OP_WR   = 0;
	localparam int OP_RD   = 1;
	localparam int OP_RXB  = 2;
	localparam int OP_RXEV = 3;
	localparam int OP_SLOT = 4;
	localparam int OP_ACK  = 5;
	localparam int OP_USER = 6;
	localparam int OP_CHK  = 7;
	localparam int OP_IDLE = 8;

	logic clk = 1'b0;
	logic wb_rst_i, reg_wr, reg_rd, rx_valid, rx_eof, rx_crc_err, rx_err, tx_slot;
	logic tx_valid, user_int, int_o, dma_req_t, dma_ack_t, dma_req_r, dma_ack_r;
	logic [2:0] reg_addr;
	byte_t reg_wdata, reg_rdata, rx_data, tx_data;

	// stimulus table, one entry per step in each queue
	int op_q[$];
	logic [2:0] addr_q[$];
	byte_t data_q[$];
	byte_t exp_q[$];
	string name_q[$];

	// reference model of the controller
	byte_t rxq[$];
	byte_t txq[$];
	int rx_lvl, tx_lvl, fr_m, rem_m, exp_int, err_count;
	int int_seen = 0;
	bit use_dma_m, req_r_m, req_t_m, ready;
	ier_t ier_m, prev_lv;
	iir_t sticky_m;
	byte_t txlen_m;
	logic [31:0] lfsr = 32'h152b5596;

	always #4 clk = ~clk;

	irda_ctrl_top UUT (
		.clk(clk), .wb_rst_i(wb_rst_i),
		.reg_wr_i(reg_wr), .reg_rd_i(reg_rd), .reg_addr_i(reg_addr),
		.reg_wdata_i(reg_wdata), .reg_rdata_o(reg_rdata),
		.rx_valid_i(rx_valid), .rx_data_i(rx_data), .rx_eof_i(rx_eof),
		.rx_crc_err_i(rx_crc_err), .rx_err_i(rx_err),
		.tx_slot_i(tx_slot), .tx_valid_o(tx_valid), .tx_data_o(tx_data),
		.user_int_i(user_int), .int_o(int_o),
		.dma_req_t_o(dma_req_t), .dma_ack_t_i(dma_ack_t),
		.dma_req_r_o(dma_req_r), .dma_ack_r_i(dma_ack_r)
	);

	// int_o is counted in clock cycles, one per pulse
	always @(posedge clk) begin
		if (!wb_rst_i && int_o) begin
			int_seen <= int_seen + 1;
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic next_rx_byte(output byte_t b);
		b = '0;
		for (int k = 0; k < 8; k++) begin
			lfsr = lfsr_next(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	function automatic ier_t cond_levels();
		ier_t lv;
		lv = '0;
		lv[0] = (rxq.size() >= RX_TRIG_BASE + TRIG_STEP * rx_lvl);
		lv[5] = (txq.size() <= TX_TRIG_BASE + TRIG_STEP * tx_lvl);
		return lv;
	endfunction

	function automatic iir_t model_iir();
		iir_t r;
		ier_t lv;
		lv = cond_levels();
		r = sticky_m;
		r[0] = lv[0];
		r[5] = lv[5];
		r[7] = (fr_m != 0);
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("ERROR %s expected %0h actual %0h", name, exp, act);
			err_count++;
		end
	endtask

	task automatic add_row(input int op, input logic [2:0] a, input byte_t d, input string n);
		op_q.push_back(op);
		addr_q.push_back(a);
		data_q.push_back(d);
		exp_q.push_back('0);
		name_q.push_back(n);
	endtask

	task automatic apply_row(input int i);
		int op;
		logic [2:0] a;
		byte_t d, b, exp_rd, exp_data;
		ier_t ev, lv, rise;
		bit exp_valid;
		op = op_q[i];
		a = addr_q[i];
		d = data_q[i];
		exp_rd = exp_q[i];
		ev = '0;
		b = '0;
		exp_valid = 1'b0;
		exp_data = '0;
		case (op)
			OP_WR: begin
				reg_wr = 1'b1;
				reg_addr = a;
				reg_wdata = d;
			end
			OP_RD: begin
				reg_rd = 1'b1;
				reg_addr = a;
				if (a == ADDR_RXDATA && rxq.size() > 0) exp_rd = rxq[0];
				if (a == ADDR_IIR) exp_rd = model_iir();
				if (a == ADDR_IER) exp_rd = {1'b0, ier_m};
			end
			OP_RXB: begin
				next_rx_byte(b);
				rx_valid = 1'b1;
				rx_data = b;
			end
			OP_RXEV: begin
				rx_eof = (a == 3'd0);
				rx_crc_err = (a == 3'd1);
				rx_err = (a == 3'd2);
			end
			OP_SLOT: tx_slot = 1'b1;
			OP_ACK: begin
				dma_ack_r = (a == 3'd0);
				dma_ack_t = (a == 3'd1);
			end
			OP_USER: user_int = 1'b1;
			OP_CHK: begin
				if (a == 3'd1) begin
					check_value(name_q[i], 32'({req_t_m, req_r_m}), 32'({dma_req_t, dma_req_r}));
				end
			end
			default: ;
		endcase
		@(posedge clk);
		#1;
		case (op)
			OP_WR: begin
				if (a == ADDR_TXDATA && txq.size() < FIFO_DEPTH) txq.push_back(d);
				if (a == ADDR_IER) ier_m = d[6:0];
				if (a == ADDR_TXLEN) txlen_m = d;
				if (a == ADDR_FCR) begin
					rx_lvl = int'(d[1:0]);
					tx_lvl = int'(d[3:2]);
					use_dma_m = d[4];
				end
				if (a == ADDR_CTRL && d[0] && fr_m == 0) begin
					fr_m = 1;
					rem_m = int'(txlen_m);
				end
			end
			OP_RD: begin
				check_value(name_q[i], 32'(exp_rd), 32'(reg_rdata));
				if (a == ADDR_RXDATA && rxq.size() > 0) rxq.pop_front();
				if (a == ADDR_IIR) sticky_m = '0;
			end
			OP_RXB: begin
				if (rxq.size() == FIFO_DEPTH) ev[3] = 1'b1;
				else rxq.push_back(b);
			end
			OP_RXEV: begin
				ev[1] = (a == 3'd0);
				ev[2] = (a == 3'd1);
				ev[4] = (a == 3'd2);
			end
			OP_SLOT: begin
				case (fr_m)
					1: begin
						exp_valid = 1'b1;
						exp_data = PREAMBLE_BYTE;
						fr_m = (rem_m == 0) ? 3 : 2;
					end
					2: begin
						if (txq.size() == 0) begin
							ev[6] = 1'b1;
							fr_m = 3;
						end else begin
							exp_valid = 1'b1;
							exp_data = txq.pop_front();
							rem_m--;
							if (rem_m == 0) fr_m = 3;
						end
					end
					3: fr_m = 0;
					default: ;
				endcase
				check_value({name_q[i], " valid"}, 32'(exp_valid), 32'(tx_valid));
				if (exp_valid) check_value(name_q[i], 32'(exp_data), 32'(tx_data));
			end
			OP_USER: begin
				check_value(name_q[i], 32'd1, 32'(int_o));
				exp_int++;
			end
			default: ;
		endcase
		// events and level rises drive the expected interrupt and dma behavior
		sticky_m = sticky_m | {1'b0, ev};
		lv = cond_levels();
		rise = (lv & ~prev_lv) | ev;
		prev_lv = lv;
		if ((rise & ier_m) != '0) exp_int++;
		if (!use_dma_m) begin
			req_r_m = 1'b0;
			req_t_m = 1'b0;
		end else begin
			if (rise[0]) req_r_m = 1'b1;
			else if (op == OP_ACK && a == 3'd0) req_r_m = 1'b0;
			if (rise[5]) req_t_m = 1'b1;
			else if (op == OP_ACK && a == 3'd1) req_t_m = 1'b0;
		end
		{reg_wr, reg_rd, rx_valid, rx_eof, rx_crc_err, rx_err} = '0;
		{tx_slot, user_int, dma_ack_r, dma_ack_t} = '0;
		@(posedge clk);
		#1;
		if (op == OP_CHK && a == 3'd0) check_value(name_q[i], 32'(exp_int), 32'(int_seen));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////////////////////////////////////////

	task automatic build_table();
		for (int l = 0; l < 4; l++) begin
			add_row(OP_WR, ADDR_FCR, byte_t'(l), "fcr");
			for (int k = 0; k < 16; k++) begin
				add_row(OP_RXB, 3'd0, 8'h00, "rx_byte");
				add_row(OP_RD, ADDR_IIR, 8'h00, "rx_trig");
			end
			for (int k = 0; k < 16; k++) add_row(OP_RD, ADDR_RXDATA, 8'h00, "rx_data");
		end
		for (int e = 0; e < 3; e++) add_row(OP_RXEV, 3'(e), 8'h00, "rx_event");
		for (int k = 0; k < 17; k++) add_row(OP_RXB, 3'd0, 8'h00, "rx_fill");
		add_row(OP_RD, ADDR_IIR, 8'h00, "sticky_set");
		add_row(OP_RD, ADDR_IIR, 8'h00, "sticky_clear");
		for (int k = 0; k < 16; k++) add_row(OP_RD, ADDR_RXDATA, 8'h00, "rx_drain");
		for (int k = 0; k < 4; k++) add_row(OP_WR, ADDR_TXDATA, byte_t'(k * 17 + 3), "tx");
		add_row(OP_WR, ADDR_TXLEN, 8'd4, "txlen");
		add_row(OP_WR, ADDR_CTRL, 8'd1, "start");
		add_row(OP_RD, ADDR_IIR, 8'h00, "tx_busy");
		for (int k = 0; k < 6; k++) add_row(OP_SLOT, 3'd0, 8'h00, "tx_frame");
		add_row(OP_RD, ADDR_IIR, 8'h00, "tx_done");
		// tx level 1 puts the low trigger at four bytes
		add_row(OP_WR, ADDR_FCR, 8'h04, "fcr");
		for (int k = 0; k < 5; k++) add_row(OP_WR, ADDR_TXDATA, byte_t'(k + 8'h40), "tx");
		add_row(OP_RD, ADDR_IIR, 8'h00, "tx_low");
		add_row(OP_WR, ADDR_TXLEN, 8'd8, "txlen");
		add_row(OP_WR, ADDR_CTRL, 8'd1, "start");
		for (int k = 0; k < 8; k++) begin
			add_row(OP_SLOT, 3'd0, 8'h00, "tx_underrun");
			add_row(OP_RD, ADDR_IIR, 8'h00, "underrun_iir");
		end
		add_row(OP_WR, ADDR_FCR, 8'h00, "fcr");
		add_row(OP_CHK, 3'd0, 8'h00, "int_masked");
		add_row(OP_WR, ADDR_IER, 8'h01, "ier");
		add_row(OP_RD, ADDR_IER, 8'h00, "ier_read");
		for (int k = 0; k < 10; k++) add_row(OP_RXB, 3'd0, 8'h00, "rx_int");
		add_row(OP_CHK, 3'd0, 8'h00, "int_rx_trig");
		for (int k = 0; k < 10; k++) add_row(OP_RD, ADDR_RXDATA, 8'h00, "rx_drain");
		for (int e = 0; e < 3; e++) begin
			add_row(OP_WR, ADDR_IER, byte_t'(e == 2 ? 8'h10 : 8'h02 << e), "ier");
			for (int k = 0; k < 3; k++) add_row(OP_RXEV, 3'(e), 8'h00, "ev_int");
			add_row(OP_CHK, 3'd0, 8'h00, "int_event");
		end
		add_row(OP_WR, ADDR_IER, 8'h00, "ier");
		add_row(OP_RXEV, 3'd0, 8'h00, "ev_masked");
		add_row(OP_USER, 3'd0, 8'h00, "user_int");
		add_row(OP_CHK, 3'd0, 8'h00, "int_user");
		add_row(OP_WR, ADDR_FCR, 8'h10, "fcr_dma");
		for (int k = 0; k < 9; k++) add_row(OP_RXB, 3'd0, 8'h00, "rx_dma");
		add_row(OP_CHK, 3'd1, 8'h00, "dma_rx_req");
		add_row(OP_ACK, 3'd0, 8'h00, "ack_r");
		add_row(OP_CHK, 3'd1, 8'h00, "dma_rx_ack");
		for (int k = 0; k < 4; k++) add_row(OP_WR, ADDR_TXDATA, byte_t'(k + 8'h80), "tx");
		add_row(OP_WR, ADDR_TXLEN, 8'd4, "txlen");
		add_row(OP_WR, ADDR_CTRL, 8'd1, "start");
		for (int k = 0; k < 3; k++) add_row(OP_SLOT, 3'd0, 8'h00, "tx_dma");
		add_row(OP_CHK, 3'd1, 8'h00, "dma_tx_req");
		add_row(OP_ACK, 3'd1, 8'h00, "ack_t");
		add_row(OP_CHK, 3'd1, 8'h00, "dma_tx_ack");
		for (int k = 0; k < 3; k++) add_row(OP_SLOT, 3'd0, 8'h00, "tx_dma");
		// drop the rx trigger and reach it again so both requests end up pending
		for (int k = 0; k < 2; k++) add_row(OP_RD, ADDR_RXDATA, 8'h00, "rx_dma_drain");
		add_row(OP_RXB, 3'd0, 8'h00, "rx_dma");
		for (int k = 0; k < 3; k++) add_row(OP_WR, ADDR_TXDATA, byte_t'(k + 8'h90), "tx");
		// tx level 1 lifts the low trigger above the three queued bytes
		add_row(OP_WR, ADDR_FCR, 8'h14, "fcr_dma");
		add_row(OP_CHK, 3'd1, 8'h00, "dma_both");
		add_row(OP_WR, ADDR_FCR, 8'h00, "fcr");
		add_row(OP_IDLE, 3'd0, 8'h00, "idle");
		add_row(OP_CHK, 3'd1, 8'h00, "dma_off");
		add_row(OP_CHK, 3'd0, 8'h00, "int_total");
	endtask

	initial begin
		{wb_rst_i, reg_wr, reg_rd, rx_valid, rx_eof, rx_crc_err, rx_err} = 7'b1000000;
		{tx_slot, user_int, dma_ack_r, dma_ack_t} = '0;
		reg_addr = '0;
		reg_wdata = '0;
		rx_data = '0;
		rx_lvl = 0;
		tx_lvl = 0;
		fr_m = 0;
		rem_m = 0;
		exp_int = 0;
		err_count = 0;
		{use_dma_m, req_r_m, req_t_m} = '0;
		ier_m = '0;
		sticky_m = '0;
		txlen_m = '0;
		prev_lv = cond_levels();
		build_table();
		ready = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		wb_rst_i = 1'b0;
		for (int i = 0; i < op_q.size(); i++) apply_row(i);
		$display("errors: %0d", err_count);
		if (err_count == 0) $display("Finished with no errors");
		else $display("Finished with errors");
		$finish;
	end

	// watchdog sized from the table length
	initial begin
		wait (ready);
		repeat (op_q.size() * 20 + 10) @(posedge clk);
		$display("timeout: the table did not finish in time");
		$display("Finished with errors");
		$finish;
	end

endmodule
